/* hdl/exu_settings.svh */
/*
  Execute stage settings: data width, register count and opcode encodings
*/
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

`define EXU_XLEN      32
`define EXU_NREGS     32

// ------------------------------------------------------------
// ALU opcodes
// ------------------------------------------------------------
`define EXU_ALU_OP_W  4
`define EXU_ALU_ADD    4'h0
`define EXU_ALU_SUB    4'h1
`define EXU_ALU_SLL    4'h2
`define EXU_ALU_SLT    4'h3
`define EXU_ALU_SLTU   4'h4
`define EXU_ALU_XOR    4'h5
`define EXU_ALU_SRL    4'h6
`define EXU_ALU_SRA    4'h7
`define EXU_ALU_OR     4'h8
`define EXU_ALU_AND    4'h9
// Forwards operand b, used by LUI
`define EXU_ALU_PASS_B 4'ha

// ------------------------------------------------------------
// Branch opcodes, funct3 style
// ------------------------------------------------------------
`define EXU_BR_OP_W   3
`define EXU_BR_EQ     3'h0
`define EXU_BR_NE     3'h1
`define EXU_BR_LT     3'h4
`define EXU_BR_GE     3'h5
`define EXU_BR_LTU    3'h6
`define EXU_BR_GEU    3'h7

// LSU opcode is carried through untouched
`define EXU_LSU_OP_W  4

`endif

/* hdl/exu_pkg.sv */
/*
  Execute stage types: data vectors, decoded issue record and
  memory-stage record
*/
`include "exu_settings.svh"

package exu_pkg;

  // ------------------------------------------------------------
  // Plain vector types
  // ------------------------------------------------------------
  typedef logic [`EXU_XLEN-1:0]            word_t;
  // Halfword aligned, bit 0 is implied zero
  typedef logic [`EXU_XLEN-1:1]            pc_t;
  typedef logic [$clog2(`EXU_NREGS)-1:0]   reg_addr_t;

  typedef logic [`EXU_ALU_OP_W-1:0]        alu_op_t;
  typedef logic [`EXU_BR_OP_W-1:0]         br_op_t;
  typedef logic [`EXU_LSU_OP_W-1:0]        lsu_op_t;

  // ------------------------------------------------------------
  // Decoded instruction entering execute
  // ------------------------------------------------------------
  typedef struct packed {
    pc_t       pc;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     imm;
    logic      use_pc;
    logic      use_imm;
    alu_op_t   alu_op;
    logic      br;
    br_op_t    br_op;
    // Static prediction from fetch
    logic      br_taken;
    logic      lsu;
    lsu_op_t   lsu_op;
    logic      rd_en;
    reg_addr_t rd_addr;
    logic      compressed;
  } ex_issue_t;

  // ------------------------------------------------------------
  // Record held in the memory-stage register
  // ------------------------------------------------------------
  typedef struct packed {
    word_t     alu_res;
    word_t     store_data;
    logic      lsu;
    lsu_op_t   lsu_op;
    logic      br;
    logic      br_taken;
    logic      rd_en;
    reg_addr_t rd_addr;
    logic      compressed;
  } ex_mem_t;

endpackage : exu_pkg

/* hdl/exu_alu.sv */
/*
  Integer ALU for the RV32I register and immediate operations
*/
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_alu (
  input  exu_pkg::word_t   a,
  input  exu_pkg::word_t   b,
  input  exu_pkg::alu_op_t alu_op,
  output exu_pkg::word_t   res
);

  logic [$clog2(`EXU_XLEN)-1:0] shamt;
  logic                         lt_signed;
  logic                         lt_unsigned;

  // Only the low bits of b shift
  assign shamt       = b[$clog2(`EXU_XLEN)-1:0];
  assign lt_signed   = $signed(a) < $signed(b);
  assign lt_unsigned = a < b;

  always_comb begin
    case (alu_op)
      `EXU_ALU_ADD:    res = a + b;
      `EXU_ALU_SUB:    res = a - b;
      `EXU_ALU_SLL:    res = a << shamt;
      `EXU_ALU_SLT:    res = exu_pkg::word_t'(lt_signed);
      `EXU_ALU_SLTU:   res = exu_pkg::word_t'(lt_unsigned);
      `EXU_ALU_XOR:    res = a ^ b;
      `EXU_ALU_SRL:    res = a >> shamt;
      `EXU_ALU_SRA:    res = exu_pkg::word_t'($signed(a) >>> shamt);
      `EXU_ALU_OR:     res = a | b;
      `EXU_ALU_AND:    res = a & b;
      `EXU_ALU_PASS_B: res = b;
      default:         res = '0;
    endcase
  end

endmodule : exu_alu

/* hdl/exu_bru.sv */
/*
  Branch comparator, evaluates the six RV32I branch conditions
*/
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_bru (
  input  logic            en,
  input  exu_pkg::br_op_t br_op,
  input  exu_pkg::word_t  a,
  input  exu_pkg::word_t  b,
  output logic            taken
);

  logic cond;
  logic eq;
  logic lt_s;
  logic lt_u;

  assign eq   = a == b;
  assign lt_s = $signed(a) < $signed(b);
  assign lt_u = a < b;

  always_comb begin
    case (br_op)
      `EXU_BR_EQ:  cond = eq;
      `EXU_BR_NE:  cond = !eq;
      `EXU_BR_LT:  cond = lt_s;
      `EXU_BR_GE:  cond = !lt_s;
      `EXU_BR_LTU: cond = lt_u;
      `EXU_BR_GEU: cond = !lt_u;
      default:     cond = 1'b0;
    endcase
  end

  // Non-branch slots never report a taken condition
  assign taken = en && cond;

endmodule : exu_bru

/* hdl/exu_operand_rf.sv */
/*
  Integer register file with retire write from the memory stage
  and a one-stage result bypass on both read ports
*/
`timescale 1ns/10ps
`include "exu_settings.svh"

module exu_operand_rf (
  input  logic                clk,
  input  logic                rst_n,
  input  exu_pkg::reg_addr_t  rs1_addr,
  input  exu_pkg::reg_addr_t  rs2_addr,
  input  exu_pkg::ex_mem_t    mem,
  output exu_pkg::word_t      rs1_data,
  output exu_pkg::word_t      rs2_data
);

  // x0 has no storage
  exu_pkg::word_t regs [1:`EXU_NREGS-1];
  logic           wr_en;

  // Loads retire elsewhere, only ALU results land here
  assign wr_en = mem.rd_en && !mem.lsu && (mem.rd_addr != '0);

  // ------------------------------------------------------------
  // Retire port
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < `EXU_NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[mem.rd_addr] <= mem.alu_res;
    end
  end

  // ------------------------------------------------------------
  // Read ports
  // ------------------------------------------------------------
  function automatic exu_pkg::word_t read_port(exu_pkg::reg_addr_t addr);
    exu_pkg::word_t val;
    if (addr == '0) begin
      val = '0;
    end else if (wr_en && (addr == mem.rd_addr)) begin
      // Result retiring this cycle is not in the array yet
      val = mem.alu_res;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rs1_data = read_port(rs1_addr);
    rs2_data = read_port(rs2_addr);
  end

  // Array is cleared by reset, so both ports stay known
  a_read_data_known: assert property (
    @(posedge clk) disable iff (!rst_n)
    !$isunknown({rs1_data, rs2_data})
  ) else $error("exu_operand_rf: read port returned unknown data");

endmodule : exu_operand_rf

/* hdl/exu.sv */
/*
  Execute stage: operand select, ALU, branch resolution against the
  static prediction, and the memory-stage register
*/
`timescale 1ns/10ps

module exu (
  input  logic               clk,
  input  logic               rst_n,
  input  exu_pkg::ex_issue_t issue,
  input  exu_pkg::word_t     rs1_data,
  input  exu_pkg::word_t     rs2_data,
  output exu_pkg::ex_mem_t   mem,
  output logic               should_br,
  output logic               br_mispredicted
);

  exu_pkg::word_t   pc_word;
  exu_pkg::word_t   op_a;
  exu_pkg::word_t   op_b;
  exu_pkg::word_t   alu_out;
  exu_pkg::word_t   res_next;
  exu_pkg::ex_mem_t mem_next;
  logic             cond_taken;
  logic             should_br_next;

  // ------------------------------------------------------------
  // Operand select and functional units
  // ------------------------------------------------------------
  assign pc_word = {issue.pc, 1'b0};
  assign op_a    = issue.use_pc  ? pc_word   : rs1_data;
  assign op_b    = issue.use_imm ? issue.imm : rs2_data;

  exu_alu i_exu_alu (
    .a      (op_a),
    .b      (op_b),
    .alu_op (issue.alu_op),
    .res    (alu_out)
  );

  exu_bru i_exu_bru (
    .en     (issue.br),
    .br_op  (issue.br_op),
    .a      (rs1_data),
    .b      (rs2_data),
    .taken  (cond_taken)
  );

  // ------------------------------------------------------------
  // Prediction check
  // ------------------------------------------------------------
  assign should_br_next  = cond_taken && !issue.br_taken;
  assign br_mispredicted = issue.br && issue.br_taken && !cond_taken;

  // Mispredict carries the fall-through address instead of the target
  always_comb begin
    if (br_mispredicted) begin
      res_next = pc_word + (issue.compressed ? exu_pkg::word_t'(2) : exu_pkg::word_t'(4));
    end else begin
      res_next = alu_out;
    end
  end

  always_comb begin
    mem_next.alu_res    = res_next;
    mem_next.store_data = rs2_data;
    mem_next.lsu        = issue.lsu;
    mem_next.lsu_op     = issue.lsu_op;
    mem_next.br         = issue.br;
    mem_next.br_taken   = issue.br_taken;
    mem_next.rd_en      = issue.rd_en;
    mem_next.rd_addr    = issue.rd_addr;
    mem_next.compressed = issue.compressed;
  end

  // ------------------------------------------------------------
  // Memory-stage register
  // ------------------------------------------------------------
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem       <= '0;
      should_br <= 1'b0;
    end else begin
      mem       <= mem_next;
      should_br <= should_br_next;
    end
  end

  a_no_double_redirect: assert property (
    @(posedge clk) disable iff (!rst_n)
    !(should_br && $past(br_mispredicted))
  ) else $error("exu: should_br and mispredict raised for one instruction");

endmodule : exu

/* hdl/exu_cluster.sv */
/*
  Execute cluster: register file operand block feeding the execute stage
*/
`timescale 1ns/10ps

module exu_cluster (
  input  logic               clk,
  input  logic               rst_n,
  input  exu_pkg::ex_issue_t issue,
  output exu_pkg::ex_mem_t   mem,
  output logic               should_br,
  output logic               br_mispredicted
);

  exu_pkg::word_t rs1_data;
  exu_pkg::word_t rs2_data;

  // Memory-stage record loops back as the retire and bypass source
  exu_operand_rf i_exu_operand_rf (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (issue.rs1_addr),
    .rs2_addr (issue.rs2_addr),
    .mem      (mem),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  exu i_exu (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue           (issue),
    .rs1_data        (rs1_data),
    .rs2_data        (rs2_data),
    .mem             (mem),
    .should_br       (should_br),
    .br_mispredicted (br_mispredicted)
  );

endmodule : exu_cluster

/* sim/tb_clkgen.sv */
/*
  Testbench clock and reset source, 20 ns clock with a 10 cycle reset
*/
`timescale 1ns/10ps

module tb_clkgen #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 10
) (
  output logic clk,
  output logic rst_n
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
  end

endmodule : tb_clkgen

/* sim/tb_exu_cluster.sv */
/*
  Testbench for the execute cluster, replays the vector file and checks
  the memory-stage record, should_br and br_mispredicted
*/
`timescale 1ns/10ps

module tb_exu_cluster;

  localparam int          NUM_VEC     = 40;
  localparam int          NUM_COL     = 20;
  localparam int          RST_TIMEOUT = 50;
  localparam int          RUN_TIMEOUT = 400;
  localparam int unsigned SEED        = 32'hf06f;

  logic               clk;
  logic               rst_n;
  exu_pkg::ex_issue_t issue;
  exu_pkg::ex_mem_t   mem;
  logic               should_br;
  logic               br_mispredicted;

  logic [31:0]        vec_mem [0:NUM_VEC*NUM_COL-1];
  int                 n_checks;
  exu_pkg::ex_mem_t   prev_mem;
  logic               prev_sbr;
  logic               have_prev;

  tb_clkgen i_tb_clkgen (
    .clk   (clk),
    .rst_n (rst_n)
  );

  exu_cluster i_exu_cluster (
    .clk             (clk),
    .rst_n           (rst_n),
    .issue           (issue),
    .mem             (mem),
    .should_br       (should_br),
    .br_mispredicted (br_mispredicted)
  );

  // ------------------------------------------------------------
  // Vector decoding
  // ------------------------------------------------------------
  function automatic exu_pkg::ex_issue_t vec_issue(int n);
    exu_pkg::ex_issue_t v;
    int                 b;
    b            = n * NUM_COL;
    v.pc         = exu_pkg::pc_t'(vec_mem[b+1] >> 1);
    v.rs1_addr   = exu_pkg::reg_addr_t'(vec_mem[b+2]);
    v.rs2_addr   = exu_pkg::reg_addr_t'(vec_mem[b+3]);
    v.imm        = vec_mem[b+4];
    v.use_pc     = vec_mem[b+5][0];
    v.use_imm    = vec_mem[b+6][0];
    v.alu_op     = exu_pkg::alu_op_t'(vec_mem[b+7]);
    v.br         = vec_mem[b+8][0];
    v.br_op      = exu_pkg::br_op_t'(vec_mem[b+9]);
    v.br_taken   = vec_mem[b+10][0];
    v.lsu        = vec_mem[b+11][0];
    v.lsu_op     = exu_pkg::lsu_op_t'(vec_mem[b+12]);
    v.rd_en      = vec_mem[b+13][0];
    v.rd_addr    = exu_pkg::reg_addr_t'(vec_mem[b+14]);
    v.compressed = vec_mem[b+15][0];
    return v;
  endfunction

  // Control fields pass straight through the stage
  function automatic exu_pkg::ex_mem_t expect_mem(exu_pkg::ex_issue_t v, int n);
    exu_pkg::ex_mem_t e;
    e.alu_res    = vec_mem[n*NUM_COL+16];
    e.store_data = vec_mem[n*NUM_COL+17];
    e.lsu        = v.lsu;
    e.lsu_op     = v.lsu_op;
    e.br         = v.br;
    e.br_taken   = v.br_taken;
    e.rd_en      = v.rd_en;
    e.rd_addr    = v.rd_addr;
    e.compressed = v.compressed;
    return e;
  endfunction

  // ------------------------------------------------------------
  // Compare tasks
  // ------------------------------------------------------------
  task automatic stop_run();
    $display("TB FAILED");
    $fatal(1, "run stopped at %0t", $time);
  endtask

  task automatic check_word(string name, exu_pkg::word_t exp, exu_pkg::word_t act);
    n_checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_bit(string name, logic exp, logic act);
    n_checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %b actual %b", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_lsu_op(string name, exu_pkg::lsu_op_t exp, exu_pkg::lsu_op_t act);
    n_checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_reg_addr(string name, exu_pkg::reg_addr_t exp, exu_pkg::reg_addr_t act);
    n_checks++;
    if (act !== exp) begin
      $display("[FAIL] %0t %s expected %h actual %h", $time, name, exp, act);
      stop_run();
    end
  endtask

  task automatic check_mem(exu_pkg::ex_mem_t e, logic e_sbr);
    check_word("mem.alu_res", e.alu_res, mem.alu_res);
    check_word("mem.store_data", e.store_data, mem.store_data);
    check_bit("mem.lsu", e.lsu, mem.lsu);
    check_lsu_op("mem.lsu_op", e.lsu_op, mem.lsu_op);
    check_bit("mem.br", e.br, mem.br);
    check_bit("mem.br_taken", e.br_taken, mem.br_taken);
    check_bit("mem.rd_en", e.rd_en, mem.rd_en);
    check_reg_addr("mem.rd_addr", e.rd_addr, mem.rd_addr);
    check_bit("mem.compressed", e.compressed, mem.compressed);
    check_bit("should_br", e_sbr, should_br);
  endtask

  // One issue slot: mispredict checked now, the record one edge later
  task automatic issue_cycle(exu_pkg::ex_issue_t v, exu_pkg::ex_mem_t e,
                             logic e_sbr, logic e_mis);
    @(posedge clk);
    issue <= v;
    @(negedge clk);
    if (have_prev) begin
      check_mem(prev_mem, prev_sbr);
    end
    check_bit("br_mispredicted", e_mis, br_mispredicted);
    prev_mem  = e;
    prev_sbr  = e_sbr;
    have_prev = 1'b1;
  endtask

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------
  initial begin : watchdog
    int cyc;
    cyc = 0;
    while (cyc < RUN_TIMEOUT) begin
      @(posedge clk);
      cyc++;
    end
    $display("Watchdog expired before the vector run completed");
    stop_run();
  end

  // ------------------------------------------------------------
  // Stimulus
  // ------------------------------------------------------------
  initial begin : main
    exu_pkg::ex_issue_t v;
    int unsigned        seed;
    int unsigned        rnd;
    int                 wait_cnt;
    issue         = '0;
    // Non-bubble record during reset, lsu keeps it out of the register file
    issue.use_imm = 1'b1;
    issue.imm     = 32'h0000_5a5a;
    issue.br      = 1'b1;
    issue.lsu     = 1'b1;
    issue.rd_en   = 1'b1;
    issue.rd_addr = 5'h1f;
    have_prev     = 1'b0;
    n_checks      = 0;
    seed          = SEED;
    rnd           = $urandom(seed);
    $readmemh("sim/exu_testdata.txt", vec_mem);
    if ($isunknown(vec_mem[NUM_VEC*NUM_COL-1])) begin
      $display("Test data file is missing or shorter than expected");
      stop_run();
    end
    wait_cnt = 0;
    while (rst_n !== 1'b1 && wait_cnt < RST_TIMEOUT) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (rst_n !== 1'b1) begin
      $display("Timed out waiting for reset release");
      stop_run();
    end
    // State right after reset
    check_bit("mem.rd_en", 1'b0, mem.rd_en);
    check_bit("mem.lsu", 1'b0, mem.lsu);
    check_bit("should_br", 1'b0, should_br);
    check_word("mem.alu_res", '0, mem.alu_res);
    // Flush the reset-time record before the vectors start
    issue_cycle('0, '0, 1'b0, 1'b0);
    for (int n = 0; n < NUM_VEC; n++) begin
      v = vec_issue(n);
      // Bubbles only in front of a new group
      if (n > 0 && vec_mem[n*NUM_COL] == 32'h1) begin
        rnd = $urandom % 3;
        for (int k = 0; k < rnd; k++) begin
          issue_cycle('0, '0, 1'b0, 1'b0);
        end
      end
      issue_cycle(v, expect_mem(v, n), vec_mem[n*NUM_COL+18][0], vec_mem[n*NUM_COL+19][0]);
    end
    issue_cycle('0, '0, 1'b0, 1'b0);
    issue_cycle('0, '0, 1'b0, 1'b0);
    if (n_checks > 0) begin
      $display("TB PASSED");
      $finish;
    end else begin
      $display("No checks were executed");
      stop_run();
    end
  end

endmodule : tb_exu_cluster

/* exu_cluster.f */
+incdir+hdl
hdl/exu_pkg.sv
hdl/exu_alu.sv
hdl/exu_bru.sv
hdl/exu_operand_rf.sv
hdl/exu.sv
hdl/exu_cluster.sv
sim/tb_clkgen.sv
sim/tb_exu_cluster.sv

/* sim/exu_testdata.txt */
// grp pc rs1 rs2 imm use_pc use_imm alu_op br br_op br_taken lsu lsu_op rd_en rd compressed
// then expected: alu_res store_data should_br br_mispredicted
1 00000100 00 00 80000000 0 1 a 0 0 0 0 0 1 01 0 80000000 00000000 0 0
0 00000104 00 00 00000005 0 1 0 0 0 0 0 0 1 02 0 00000005 00000000 0 0
0 00000108 00 00 fffffff0 0 1 0 0 0 0 0 0 1 03 0 fffffff0 00000000 0 0
0 0000010c 00 00 12345000 0 1 a 0 0 0 0 0 1 04 0 12345000 00000000 0 0
0 00000110 04 00 00000abc 0 1 0 0 0 0 0 0 1 05 0 12345abc 00000000 0 0
0 00000114 00 00 000007ff 0 1 0 0 0 0 0 0 1 00 0 000007ff 00000000 0 0
1 00000118 04 05 00000000 0 0 0 0 0 0 0 0 1 06 0 2468aabc 12345abc 0 0
0 0000011c 02 03 00000000 0 0 1 0 0 0 0 0 1 07 0 00000015 fffffff0 0 0
0 00000120 05 02 00000000 0 0 2 0 0 0 0 0 1 08 0 468b5780 00000005 0 0
0 00000124 01 02 00000000 0 0 3 0 0 0 0 0 1 09 0 00000001 00000005 0 0
0 00000128 01 02 00000000 0 0 4 0 0 0 0 0 1 0a 0 00000000 00000005 0 0
0 0000012c 04 05 00000000 0 0 5 0 0 0 0 0 1 0b 0 00000abc 12345abc 0 0
0 00000130 01 02 00000000 0 0 6 0 0 0 0 0 1 0c 0 04000000 00000005 0 0
0 00000134 01 02 00000000 0 0 7 0 0 0 0 0 1 0d 0 fc000000 00000005 0 0
0 00000138 03 02 00000000 0 0 8 0 0 0 0 0 1 0e 0 fffffff5 00000005 0 0
0 0000013c 05 03 00000000 0 0 9 0 0 0 0 0 1 0f 0 12345ab0 fffffff0 0 0
0 00000140 03 05 00000000 0 0 7 0 0 0 0 0 1 10 0 ffffffff 12345abc 0 0
0 00000144 00 00 00000000 0 0 0 0 0 0 0 0 1 11 0 00000000 00000000 0 0
1 00000148 02 00 00000010 0 1 0 0 0 0 0 0 1 12 0 00000015 00000000 0 0
0 0000014c 12 12 00000000 0 0 0 0 0 0 0 0 1 13 0 0000002a 00000015 0 0
0 00000150 12 13 00000000 0 0 0 0 0 0 0 0 1 14 0 0000003f 0000002a 0 0
0 00000154 14 12 00000000 0 0 1 0 0 0 0 0 1 15 0 0000002a 00000015 0 0
1 00000158 02 02 00000040 1 1 0 1 0 0 0 0 0 00 0 00000198 00000005 1 0
0 0000015c 02 02 ffffffe0 1 1 0 1 1 0 0 0 0 00 0 0000013c 00000005 0 0
0 00000160 01 02 00000010 1 1 0 1 4 0 0 0 0 00 0 00000170 00000005 1 0
0 00000164 01 02 00000008 1 1 0 1 6 0 0 0 0 00 0 0000016c 00000005 0 0
0 00000168 03 02 00000100 1 1 0 1 5 0 0 0 0 00 0 00000268 00000005 0 0
0 0000016c 03 02 00000020 1 1 0 1 7 0 0 0 0 00 0 0000018c 00000005 1 0
1 00000170 02 03 00000040 1 1 0 1 0 1 0 0 0 00 0 00000174 fffffff0 0 1
0 00000174 12 12 00000040 1 1 0 1 1 1 0 0 0 00 1 00000176 00000015 0 1
0 00000178 01 02 00000040 1 1 0 1 5 1 0 0 0 00 0 0000017c 00000005 0 1
0 0000017c 02 01 00000040 1 1 0 1 4 1 0 0 0 00 1 0000017e 80000000 0 1
0 00000180 02 03 00000040 1 1 0 1 7 1 0 0 0 00 0 00000184 fffffff0 0 1
0 00000184 02 03 00000030 1 1 0 1 6 1 0 0 0 00 0 000001b4 fffffff0 0 0
1 00000188 04 05 00000008 0 1 0 0 0 0 1 2 0 00 0 12345008 12345abc 0 0
1 0000018c 00 00 00000055 0 1 0 0 0 0 0 0 1 16 0 00000055 00000000 0 0
0 00000190 02 16 00000000 0 1 0 0 0 0 1 a 0 00 0 00000005 00000055 0 0
1 00000194 02 00 00000004 0 1 0 0 0 0 1 4 1 06 0 00000009 00000000 0 0
0 00000198 06 00 00000000 0 0 0 0 0 0 0 0 1 17 0 2468aabc 00000000 0 0
0 0000019c 06 00 00000000 0 0 8 0 0 0 0 0 1 18 0 2468aabc 00000000 0 0
